// File: dv/exChecker.sv
/*
 * Execute stage result checker.
 * Holds the expected entries queued by the driver, pops one on every
 * resultValid and compares result, flags, hi and lo, and that the
 * result came one cycle after its request. Also checks the state
 * right after reset.
 */
`timescale 1ns/1ps

module exChecker
    import exPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wordT    result,
    input  exFlagsT flags,
    input  logic    resultValid,
    input  wordT    hi,
    input  wordT    lo,
    output int      passCount,
    output int      errorCount,
    output int      pending
);

    string   nameQ[$];
    wordT    resultQ[$];
    exFlagsT flagsQ[$];
    wordT    hiQ[$];
    wordT    loQ[$];
    int      dueQ[$];

    string   expName;
    wordT    expResult;
    exFlagsT expFlags;
    wordT    expHi;
    wordT    expLo;
    int      expDue;
    int      edgeCount;

    task automatic addExpected(input string name, input wordT res, input exFlagsT f,
                               input wordT h, input wordT l);
        nameQ.push_back(name);
        resultQ.push_back(res);
        flagsQ.push_back(f);
        hiQ.push_back(h);
        loQ.push_back(l);
        dueQ.push_back(edgeCount + 1); // The request is taken at the next edge.
        pending = pending + 1;
    endtask

    always @(posedge clk)
        edgeCount = edgeCount + 1;

    // Outputs are sampled on the falling edge, half a cycle after they settle.
    initial
    begin
        @(negedge rst);
        @(negedge clk);
        if (resultValid !== 1'b0 || hi !== '0 || lo !== '0)
        begin
            $display("ERROR reset expected valid=0 hi=%h lo=%h actual valid=%b hi=%h lo=%h",
                     32'h0, 32'h0, resultValid, hi, lo);
            errorCount = errorCount + 1;
        end
        else
        begin
            $display("PASS  reset");
            passCount = passCount + 1;
        end
    end

    always @(negedge clk)
    begin
        if (!rst && resultValid)
        begin
            if (pending == 0)
            begin
                $display("Unexpected resultValid at %0t with no test waiting for it", $time);
                errorCount = errorCount + 1;
            end
            else
            begin
                expName   = nameQ.pop_front();
                expResult = resultQ.pop_front();
                expFlags  = flagsQ.pop_front();
                expHi     = hiQ.pop_front();
                expLo     = loQ.pop_front();
                expDue    = dueQ.pop_front();
                pending   = pending - 1;
                if (edgeCount != expDue)
                begin
                    $display("Result of %s came %0d cycles after its request instead of 1",
                             expName, edgeCount - expDue + 1);
                    errorCount = errorCount + 1;
                end
                else if (result !== expResult || flags !== expFlags || hi !== expHi ||
                         lo !== expLo)
                begin
                    $write("ERROR %s expected result=%h flags=%b hi=%h lo=%h", expName,
                           expResult, expFlags, expHi, expLo);
                    $display(" actual result=%h flags=%b hi=%h lo=%h",
                             result, flags, hi, lo);
                    errorCount = errorCount + 1;
                end
                else
                begin
                    $display("PASS  %s", expName);
                    passCount = passCount + 1;
                end
            end
        end
    end

    task automatic finalReport();
        if (pending != 0)
        begin
            $display("%0d expected results were never produced by the DUT", pending);
            errorCount = errorCount + 1;
        end
        $display("Tests passed: %0d, failed: %0d", passCount, errorCount);
    endtask

endmodule

// File: dv/exClockGen.sv
/*
 * Testbench clock and reset generator.
 * 8 ns clock, reset held high for the first 16 rising edges.
 */
`timescale 1ns/1ps

module exClockGen
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0; // Released on the edge, like a registered reset.
    end

endmodule

// File: dv/exStageTb.sv
/*
 * Execute stage testbench top.
 * Builds a table of requests with hand-computed results, flags and
 * HI/LO values, drives it one row per cycle with an idle cycle
 * between groups, and hands each row's expectations to the checker.
 */
`timescale 1ns/1ps

module exStageTb;
    import exPkg::*;

    logic    clk;
    logic    rst;
    exReqT   req;
    wordT    result;
    exFlagsT flags;
    logic    resultValid;
    wordT    hi;
    wordT    lo;
    int      passCount;
    int      errorCount;
    int      pending;
    int      cycleCount;
    int      timeoutLimit;
    int      drainCycles;

    string   rowName[$];
    exReqT   rowReq[$];
    wordT    rowResult[$];
    exFlagsT rowFlags[$];
    wordT    rowHi[$];
    wordT    rowLo[$];
    bit      rowIdleAfter[$];

    exClockGen exClockGen_inst (.clk(clk), .rst(rst));

    exStage exStage_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .result      (result),
        .flags       (flags),
        .resultValid (resultValid),
        .hi          (hi),
        .lo          (lo)
    );

    exChecker exChecker_inst (
        .clk         (clk),
        .rst         (rst),
        .result      (result),
        .flags       (flags),
        .resultValid (resultValid),
        .hi          (hi),
        .lo          (lo),
        .passCount   (passCount),
        .errorCount  (errorCount),
        .pending     (pending)
    );

    // Flags are written as {c, z, o, n}.
    task automatic addRow(input string name, input opcodeT op, input funcT fn,
                          input shamtT sh, input wordT a, input wordT b, input logic selB,
                          input wordT res, input exFlagsT f, input wordT h, input wordT l);
        exReqT r;
        r.valid  = 1'b1;
        r.opcode = op;
        r.func   = fn;
        r.shamt  = sh;
        r.a      = a;
        r.b      = b;
        r.selB   = selB;
        rowName.push_back(name);
        rowReq.push_back(r);
        rowResult.push_back(res);
        rowFlags.push_back(f);
        rowHi.push_back(h);
        rowLo.push_back(l);
        rowIdleAfter.push_back(1'b0);
    endtask

    task automatic endGroup();
        rowIdleAfter[rowIdleAfter.size() - 1] = 1'b1;
    endtask

    task automatic buildTable();
        addRow("add_ovf", opSpecial, fnAdd, 5'd0, 32'h7FFFFFFF, 32'h1, 1'b1,
               32'h80000000, 4'b0011, 32'h0, 32'h0);
        addRow("addu_carry", opSpecial, fnAddu, 5'd0, 32'hFFFFFFFF, 32'h1, 1'b1,
               32'h00000000, 4'b1100, 32'h0, 32'h0);
        addRow("sub_borrow", opSpecial, fnSub, 5'd0, 32'h1, 32'h2, 1'b1,
               32'hFFFFFFFF, 4'b1001, 32'h0, 32'h0);
        addRow("sub_ovf", opSpecial, fnSub, 5'd0, 32'h80000000, 32'h1, 1'b1,
               32'h7FFFFFFF, 4'b0010, 32'h0, 32'h0);
        addRow("subu_noborrow", opSpecial, fnSubu, 5'd0, 32'h5, 32'h3, 1'b1,
               32'h00000002, 4'b0000, 32'h0, 32'h0);
        endGroup();
        addRow("and", opSpecial, fnAnd, 5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 1'b1,
               32'hF000F000, 4'b0001, 32'h0, 32'h0);
        addRow("or", opSpecial, fnOr, 5'd0, 32'hF0F0F0F0, 32'h0F0F0000, 1'b1,
               32'hFFFFF0F0, 4'b0001, 32'h0, 32'h0);
        addRow("xor", opSpecial, fnXor, 5'd0, 32'hA5A5A5A5, 32'hFFFF0000, 1'b1,
               32'h5A5AA5A5, 4'b0000, 32'h0, 32'h0);
        addRow("nor", opSpecial, fnNor, 5'd0, 32'h0000FFFF, 32'h00FF0000, 1'b1,
               32'hFF000000, 4'b0001, 32'h0, 32'h0);
        addRow("sll", opSpecial, fnSll, 5'd31, 32'h0, 32'h1, 1'b1,
               32'h80000000, 4'b0001, 32'h0, 32'h0);
        addRow("srl", opSpecial, fnSrl, 5'd4, 32'h0, 32'h80000000, 1'b1,
               32'h08000000, 4'b0000, 32'h0, 32'h0);
        addRow("sra_neg", opSpecial, fnSra, 5'd4, 32'h0, 32'h80000000, 1'b1,
               32'hF8000000, 4'b0001, 32'h0, 32'h0);
        addRow("slt", opSpecial, fnSlt, 5'd0, 32'hFFFFFFFF, 32'h1, 1'b1,
               32'h00000001, 4'b0000, 32'h0, 32'h0);
        addRow("sltu", opSpecial, fnSltu, 5'd0, 32'hFFFFFFFF, 32'h1, 1'b1,
               32'h00000000, 4'b0100, 32'h0, 32'h0);
        endGroup();
        addRow("clz_zero", opSpecial2, fn2Clz, 5'd0, 32'h0, 32'h0, 1'b1,
               32'd32, 4'b0000, 32'h0, 32'h0);
        addRow("clz_msb", opSpecial2, fn2Clz, 5'd0, 32'h80000000, 32'h0, 1'b1,
               32'd0, 4'b0100, 32'h0, 32'h0);
        addRow("clz_mid", opSpecial2, fn2Clz, 5'd0, 32'h00010000, 32'h0, 1'b1,
               32'd15, 4'b0000, 32'h0, 32'h0);
        addRow("clo_all", opSpecial2, fn2Clo, 5'd0, 32'hFFFFFFFF, 32'h0, 1'b1,
               32'd32, 4'b0000, 32'h0, 32'h0);
        addRow("clo_thirty", opSpecial2, fn2Clo, 5'd0, 32'hFFFFFFFC, 32'h0, 1'b1,
               32'd30, 4'b0000, 32'h0, 32'h0);
        endGroup();
        addRow("mult_neg", opSpecial, fnMult, 5'd0, 32'hFFFFFFFD, 32'h5, 1'b1,
               32'h0, 4'b0000, 32'hFFFFFFFF, 32'hFFFFFFF1);
        addRow("mfhi_mult", opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, 1'b1,
               32'hFFFFFFFF, 4'b0001, 32'hFFFFFFFF, 32'hFFFFFFF1);
        addRow("mflo_mult", opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, 1'b1,
               32'hFFFFFFF1, 4'b0001, 32'hFFFFFFFF, 32'hFFFFFFF1);
        addRow("multu", opSpecial, fnMultu, 5'd0, 32'hFFFFFFFD, 32'h5, 1'b1,
               32'h0, 4'b0000, 32'h00000004, 32'hFFFFFFF1);
        addRow("mfhi_multu", opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, 1'b1,
               32'h00000004, 4'b0000, 32'h00000004, 32'hFFFFFFF1);
        addRow("mflo_multu", opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, 1'b1,
               32'hFFFFFFF1, 4'b0001, 32'h00000004, 32'hFFFFFFF1);
        endGroup();
        // Starts from HI:LO = 4:FFFFFFF1, so the first MADDU carries into HI.
        addRow("maddu_carry", opSpecial2, fn2Maddu, 5'd0, 32'h10, 32'h1, 1'b1,
               32'h0, 4'b0000, 32'h5, 32'h1);
        addRow("maddu_hi", opSpecial2, fn2Maddu, 5'd0, 32'h80000000, 32'h4, 1'b1,
               32'h0, 4'b0000, 32'h7, 32'h1);
        addRow("mfhi_madd", opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, 1'b1,
               32'h7, 4'b0000, 32'h7, 32'h1);
        addRow("mflo_madd", opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, 1'b1,
               32'h1, 4'b0000, 32'h7, 32'h1);
        addRow("madd_selb_low", opSpecial2, fn2Madd, 5'd0, 32'hFFFFFFFE, 32'h12345678, 1'b0,
               32'h0, 4'b0000, 32'h6, 32'hFFFFFFFF);
        addRow("mul_neg", opSpecial2, fn2Mul, 5'd0, 32'hFFFFFFFC, 32'h3, 1'b1,
               32'hFFFFFFF4, 4'b0001, 32'h6, 32'hFFFFFFFF);
        addRow("mul_wrap", opSpecial2, fn2Mul, 5'd0, 32'h00010000, 32'h00010000, 1'b1,
               32'h0, 4'b0100, 32'h6, 32'hFFFFFFFF);
    endtask

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
        begin
            $display("Timeout after %0d cycles with %0d results still outstanding",
                     cycleCount, pending);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        req = '0;
        cycleCount = 0;
        timeoutLimit = 0;
        drainCycles = 0;
        buildTable();
        timeoutLimit = 2 * rowName.size() + 64;

        @(negedge rst);
        for (int i = 0; i < rowName.size(); i++)
        begin
            @(posedge clk);
            #1;
            req = rowReq[i];
            exChecker_inst.addExpected(rowName[i], rowResult[i], rowFlags[i], rowHi[i],
                                       rowLo[i]);
            if (rowIdleAfter[i])
            begin
                @(posedge clk);
                #1;
                req = '0;
            end
        end
        @(posedge clk);
        #1;
        req = '0;

        // The last result is due one cycle after its request.
        while (pending != 0 && drainCycles < 4)
        begin
            @(posedge clk);
            drainCycles = drainCycles + 1;
        end
        repeat (3) @(posedge clk); // Any stray resultValid would show up here.

        exChecker_inst.finalReport();
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: hw/exAlu.sv
/*
 * Integer ALU of the execute stage.
 * Add, subtract, logic, shift and set-less-than for SPECIAL
 * instructions, with carry, zero, overflow and negative flags.
 */
`timescale 1ns/1ps

module exAlu
    import exPkg::*;
(
    input  opcodeT  opcode,
    input  funcT    func,
    input  shamtT   shamt,
    input  wordT    a,
    input  wordT    b,
    output wordT    result,
    output exFlagsT flags
);

    logic [32:0] sum;
    logic [32:0] diff;
    logic        addOvf;
    logic        subOvf;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b}; // Bit 32 is the borrow.

    assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb
    begin
        result  = '0;
        flags.c = 1'b0;
        flags.o = 1'b0;

        if (opcode == opSpecial)
        begin
            case (func)
                fnAdd:
                begin
                    result  = sum[31:0];
                    flags.c = sum[32];
                    flags.o = addOvf;
                end
                fnAddu:
                begin
                    result  = sum[31:0];
                    flags.c = sum[32];
                end
                fnSub:
                begin
                    result  = diff[31:0];
                    flags.c = diff[32];
                    flags.o = subOvf;
                end
                fnSubu:
                begin
                    result  = diff[31:0];
                    flags.c = diff[32];
                end
                fnAnd:  result = a & b;
                fnOr:   result = a | b;
                fnXor:  result = a ^ b;
                fnNor:  result = ~(a | b);
                fnSlt:  result = wordT'($signed(a) < $signed(b));
                fnSltu: result = wordT'(a < b);
                // Shifts operate on the second operand, as rt does in MIPS.
                fnSll:  result = b << shamt;
                fnSrl:  result = b >> shamt;
                fnSra:  result = $signed(b) >>> shamt;
                default: result = '0;
            endcase
        end

        flags.z = (result == '0);
        flags.n = result[31];
    end

endmodule

// File: hw/exHiLo.sv
/*
 * Multiplier and HI/LO register pair.
 * Signed or unsigned 32x32 product. MULT and MULTU load HI:LO,
 * MADD and MADDU accumulate into it. MUL only uses the product.
 */
`timescale 1ns/1ps

module exHiLo
    import exPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   valid,
    input  opcodeT opcode,
    input  funcT   func,
    input  wordT   a,
    input  wordT   mB,
    output dwordT  product,
    output wordT   hi,
    output wordT   lo
);

    logic signed [63:0] sProd;
    dwordT              uProd;
    dwordT              hiLo;
    logic               isSpecial;
    logic               isSpecial2;
    logic               isMult;
    logic               isMultu;
    logic               isMadd;
    logic               isMaddu;
    logic               isUnsigned;

    assign isSpecial  = (opcode == opSpecial);
    assign isSpecial2 = (opcode == opSpecial2);

    assign isMult  = isSpecial && (func == fnMult);
    assign isMultu = isSpecial && (func == fnMultu);
    assign isMadd  = isSpecial2 && (func == fn2Madd);
    assign isMaddu = isSpecial2 && (func == fn2Maddu);

    assign isUnsigned = isMultu || isMaddu;

    // Both products are formed apart so the signed one keeps its sign extension.
    assign sProd = $signed(a) * $signed(mB);
    assign uProd = {32'd0, a} * {32'd0, mB};

    assign product = isUnsigned ? uProd : dwordT'(sProd);

    // MUL writes a general register only, so HI:LO is left alone.
    always_ff @(posedge clk)
    begin
        if (rst)
            hiLo <= '0;
        else if (valid)
        begin
            if (isMult || isMultu)
                hiLo <= product;
            else if (isMadd || isMaddu)
                hiLo <= hiLo + product; // Wraps modulo 2^64.
        end
    end

    assign hi = hiLo[63:32];
    assign lo = hiLo[31:0];

endmodule

// File: hw/exMult.sv
/*
 * Leading-bit counter and multiply-operand select.
 * CLZ and CLO count the leading zeros or ones of a, other codes
 * pass a through. mB feeds the multiplier with b or the constant 1.
 */
`timescale 1ns/1ps

module exMult
    import exPkg::*;
(
    input  funcT    func,
    input  wordT    a,
    input  wordT    b,
    input  logic    selB,
    output dwordT   out,
    output exFlagsT flags,
    output wordT    mB
);

    logic       countOnes;
    logic [5:0] lead;
    logic       done;

    assign mB        = selB ? b : 32'd1;
    assign countOnes = (func == fn2Clo);

    // Count from the top while bits still match the wanted value.
    always_comb
    begin
        lead = 6'd0;
        done = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (!done && (a[i] == countOnes))
                lead = lead + 6'd1;
            else
                done = 1'b1;
        end
    end

    always_comb
    begin
        case (func)
            fn2Clz, fn2Clo: out = dwordT'(lead);
            default:        out = dwordT'(a);
        endcase

        flags.c = out[32];
        flags.z = (out[31:0] == '0); // Set only for a zero count.
        flags.o = out[32];
        flags.n = out[31];
    end

endmodule

// File: hw/exPkg.sv
/*
 * Execute stage package.
 * Word types, major opcode and function codes, the request bundle
 * that enters the stage and the condition flag bundle it produces.
 */
package exPkg;

    typedef logic [31:0] wordT;  // Operand or result word.
    typedef logic [63:0] dwordT; // Product or HI:LO pair.
    typedef logic [4:0]  shamtT;
    typedef logic [5:0]  funcT;  // Meaning depends on the opcode.

    typedef enum logic [5:0] {
        opSpecial  = 6'h00,
        opSpecial2 = 6'h1C
    } opcodeT;

    // SPECIAL function codes.
    localparam funcT fnSll   = 6'h00;
    localparam funcT fnSrl   = 6'h02;
    localparam funcT fnSra   = 6'h03;
    localparam funcT fnMfhi  = 6'h10;
    localparam funcT fnMflo  = 6'h12;
    localparam funcT fnMult  = 6'h18;
    localparam funcT fnMultu = 6'h19;
    localparam funcT fnAdd   = 6'h20;
    localparam funcT fnAddu  = 6'h21;
    localparam funcT fnSub   = 6'h22;
    localparam funcT fnSubu  = 6'h23;
    localparam funcT fnAnd   = 6'h24;
    localparam funcT fnOr    = 6'h25;
    localparam funcT fnXor   = 6'h26;
    localparam funcT fnNor   = 6'h27;
    localparam funcT fnSlt   = 6'h2A;
    localparam funcT fnSltu  = 6'h2B;

    // SPECIAL2 function codes.
    localparam funcT fn2Madd  = 6'h00;
    localparam funcT fn2Maddu = 6'h01;
    localparam funcT fn2Mul   = 6'h02;
    localparam funcT fn2Clz   = 6'h20;
    localparam funcT fn2Clo   = 6'h21;

    typedef struct packed {
        logic   valid;
        opcodeT opcode;
        funcT   func;
        shamtT  shamt;
        wordT   a;
        wordT   b;
        logic   selB; // Low means the second multiplier operand is 1.
    } exReqT;

    typedef struct packed {
        logic c;
        logic z;
        logic o;
        logic n;
    } exFlagsT;

endpackage

// File: hw/exResultSel.sv
/*
 * Result select and output register of the execute stage.
 * Picks the unit result and flags for the instruction and
 * registers them together with the valid strobe.
 */
`timescale 1ns/1ps

module exResultSel
    import exPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  exReqT   req,
    input  wordT    aluResult,
    input  exFlagsT aluFlags,
    input  dwordT   multOut,
    input  exFlagsT multFlags,
    input  dwordT   product,
    input  wordT    hi,
    input  wordT    lo,
    output wordT    result,
    output exFlagsT flags,
    output logic    resultValid
);

    wordT    selResult;
    exFlagsT selFlags;

    // Builds z and n for a word, with c and o cleared.
    function automatic exFlagsT wordFlags(input wordT w);
        exFlagsT f;
        f   = '0;
        f.z = (w == '0);
        f.n = w[31];
        return f;
    endfunction

    always_comb
    begin
        selResult = '0;
        selFlags  = '0;
        case (req.opcode)
            opSpecial:
                case (req.func)
                    fnMfhi:
                    begin
                        selResult = hi;
                        selFlags  = wordFlags(hi);
                    end
                    fnMflo:
                    begin
                        selResult = lo;
                        selFlags  = wordFlags(lo);
                    end
                    fnMult, fnMultu: ; // No general register is written.
                    default:
                    begin
                        selResult = aluResult;
                        selFlags  = aluFlags;
                    end
                endcase
            opSpecial2:
                case (req.func)
                    fn2Clz, fn2Clo:
                    begin
                        selResult = multOut[31:0];
                        selFlags  = multFlags;
                    end
                    fn2Mul:
                    begin
                        selResult = product[31:0];
                        selFlags  = wordFlags(product[31:0]);
                    end
                    default: ;
                endcase
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            resultValid <= 1'b0;
            result      <= '0;
            flags       <= '0;
        end
        else
        begin
            resultValid <= req.valid;
            if (req.valid)
            begin
                result <= selResult;
                flags  <= selFlags;
            end
        end
    end

endmodule

// File: hw/exStage.sv
/*
 * Execute stage top level.
 * Fans the request out to the ALU, the leading-bit counter and the
 * HI/LO multiplier, then registers the selected result one cycle later.
 */
`timescale 1ns/1ps

module exStage
    import exPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  exReqT   req,
    output wordT    result,
    output exFlagsT flags,
    output logic    resultValid,
    output wordT    hi,
    output wordT    lo
);

    wordT    aluResult;
    exFlagsT aluFlags;
    dwordT   multOut;
    exFlagsT multFlags;
    wordT    mB;
    dwordT   product;

    exAlu exAlu_inst (
        .opcode (req.opcode),
        .func   (req.func),
        .shamt  (req.shamt),
        .a      (req.a),
        .b      (req.b),
        .result (aluResult),
        .flags  (aluFlags)
    );

    exMult exMult_inst (
        .func  (req.func),
        .a     (req.a),
        .b     (req.b),
        .selB  (req.selB),
        .out   (multOut),
        .flags (multFlags),
        .mB    (mB)
    );

    exHiLo exHiLo_inst (
        .clk     (clk),
        .rst     (rst),
        .valid   (req.valid),
        .opcode  (req.opcode),
        .func    (req.func),
        .a       (req.a),
        .mB      (mB),
        .product (product),
        .hi      (hi),
        .lo      (lo)
    );

    exResultSel exResultSel_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .aluResult   (aluResult),
        .aluFlags    (aluFlags),
        .multOut     (multOut),
        .multFlags   (multFlags),
        .product     (product),
        .hi          (hi),
        .lo          (lo),
        .result      (result),
        .flags       (flags),
        .resultValid (resultValid)
    );

endmodule

// File: src.f
hw/exPkg.sv
hw/exAlu.sv
hw/exMult.sv
hw/exHiLo.sv
hw/exResultSel.sv
hw/exStage.sv
dv/exClockGen.sv
dv/exChecker.sv
dv/exStageTb.sv
